/* Makefile */
# Verilator build and run for the compute tile

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= stile_tb
RTL_TOP    ?= stile_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+logic
+incdir+sim
logic/stile_buf_pkg.sv
logic/stile_mac_pkg.sv
logic/weight_buf.sv
logic/act_buf.sv
logic/mac_unit.sv
logic/stile_top.sv
sim/stile_tb.sv

/* logic/act_buf.sv */
// Double-pumped activation RAM with phase toggle and per-phase address selection
`timescale 1ns/1ps
`default_nettype none

`include "stile_macros.svh"

module act_buf (
  input  wire logic                      clk_h,
  input  wire logic                      rst_n,
  input  wire stile_buf_pkg::actbuf_wr_t wr,
  input  wire stile_buf_pkg::actbuf_rd_t rd,
  output stile_mac_pkg::act_t            act
);

  import stile_mac_pkg::*;

  localparam int ACT_DEPTH = 1 << `STILE_ACT_ADDR_W;

  act_t mem [0:ACT_DEPTH-1]; // Distributed RAM, async read

  logic                         phase;   // 0 then 1 within a slow beat
  logic [`STILE_ACT_ADDR_W-1:0] wr_addr; // Pair address plus phase bit
  act_t                         wr_data; // Half picked for this phase
  logic [`STILE_ACT_ADDR_W-1:0] rd_sel;  // Base or base plus increment

  // Phase toggle
  // Cleared in reset so the first cycle is phase 0
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else begin
      phase <= ~phase;
    end
  end

  // Lo half at even address, hi half at odd address
  assign wr_addr = {wr.addrh, phase};
  assign wr_data = phase ? wr.data.half.hi : wr.data.half.lo;

  always_ff @(posedge clk_h) begin
    if (wr.en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Second phase steps the read address
  assign rd_sel = phase ? (rd.addr + rd.increment) : rd.addr; // Wraps in 7 bits

  // Combinational read in the same cycle
  assign act = mem[rd_sel];

endmodule

`default_nettype wire

/* logic/mac_unit.sv */
// Optional odd-tile skew, then a three-stage multiply-accumulate pipeline
`timescale 1ns/1ps
`default_nettype none

`include "stile_macros.svh"

module mac_unit #(
  parameter bit tile_odd = 1'b0 // Odd tiles skew operands one extra cycle
) (
  input  wire logic                     clk_h,
  input  wire logic                     rst_n,
  input  wire stile_mac_pkg::weight_t   weight,
  input  wire stile_mac_pkg::act_t      act,
  input  wire stile_mac_pkg::psum_src_e psum_src,
  input  wire stile_mac_pkg::psum_t     psum_in,
  input  wire stile_mac_pkg::psum_t     psum_casin,
  output stile_mac_pkg::psum_t          psum_out
);

  import stile_mac_pkg::*;

  localparam int PROD_W = `STILE_WBUF_DATA_W + `STILE_ACT_DATA_W; // 24-bit product

  weight_t   w_skew;   // After optional skew
  act_t      a_skew;
  psum_src_e src_skew;

  weight_t     w_q;     // Operand stage
  act_t        a_q;
  psum_src_e   src_q;
  logic [PROD_W-1:0] prod_q; // Product stage
  psum_src_e   src_m;   // Select riding with the product
  psum_t       psum_loc_q; // Local psum, aligned with the product
  psum_t       psum_sel;

  // Skew stage, only in odd tiles
  if (tile_odd) begin : g_skew
    always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
        w_skew   <= '0;
        a_skew   <= '0;
        src_skew <= src_local;
      end else begin
        w_skew   <= weight;
        a_skew   <= act;
        src_skew <= psum_src;
      end
    end
  end else begin : g_no_skew
    assign w_skew   = weight;
    assign a_skew   = act;
    assign src_skew = psum_src;
  end

  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      w_q        <= '0;
      a_q        <= '0;
      src_q      <= src_local;
      prod_q     <= '0;
      src_m      <= src_local;
      psum_loc_q <= '0;
      psum_out   <= '0;
    end else begin
      w_q        <= w_skew;    // Operand registers
      a_q        <= a_skew;
      src_q      <= src_skew;
      prod_q     <= w_q * a_q; // Unsigned multiply
      src_m      <= src_q;
      psum_loc_q <= psum_in;   // Registered alongside the product
      psum_out   <= psum_t'(prod_q) + psum_sel; // Modulo 2^48
    end
  end

  // Cascade input goes straight into the adder
  assign psum_sel = (src_m == src_cascade) ? psum_casin : psum_loc_q;

endmodule

`default_nettype wire

/* logic/stile_buf_pkg.sv */
// Buffer-side types: weight write, activation pair union, activation write and read
`default_nettype none

`include "stile_macros.svh"

package stile_buf_pkg;

  // Weight buffer write port, one word per cycle
  typedef struct packed {
    logic                          en;   // Write strobe
    logic [`STILE_WBUF_ADDR_W-1:0] addr;
    logic [`STILE_WBUF_DATA_W-1:0] data;
  } wbuf_wr_t; // 27 bits

  // Two activations carried in one slow beat
  typedef union packed {
    logic [2*`STILE_ACT_DATA_W-1:0] word; // Flat view
    struct packed {
      logic [`STILE_ACT_DATA_W-1:0] hi;   // Written in phase 1
      logic [`STILE_ACT_DATA_W-1:0] lo;   // Written in phase 0
    } half;
  } act_pair_u;

  // Activation write, held for a whole beat
  typedef struct packed {
    logic                          en;
    logic [`STILE_ACT_ADDRH_W-1:0] addrh; // Pair address
    act_pair_u                     data;
  } actbuf_wr_t; // 23 bits

  // Activation read, base plus second-phase offset
  typedef struct packed {
    logic [`STILE_ACT_ADDR_W-1:0] addr;
    logic [`STILE_ACT_ADDR_W-1:0] increment; // Added in phase 1
  } actbuf_rd_t; // 14 bits

endpackage

`default_nettype wire

/* logic/stile_mac_pkg.sv */
// Compute-side types: partial sum, weight and activation operands, psum source select
`default_nettype none

`include "stile_macros.svh"

package stile_mac_pkg;

  // Accumulator word, wraps modulo 2^48
  typedef logic [`STILE_PSUM_W-1:0] psum_t;

  // Operands as they leave the buffers
  typedef logic [`STILE_WBUF_DATA_W-1:0] weight_t;
  typedef logic [`STILE_ACT_DATA_W-1:0]  act_t;

  // Which partial sum the last stage adds
  typedef enum logic {
    src_local   = 1'b0, // psum_in, first tile of a chain
    src_cascade = 1'b1  // psum_casin from the neighbour
  } psum_src_e;

endpackage

`default_nettype wire

/* logic/stile_macros.svh */
// Width and depth macros for the tile buffers, operands and partial sums
`ifndef STILE_MACROS_SVH
`define STILE_MACROS_SVH

// Weight buffer, one block RAM of 1024 entries
`define STILE_WBUF_ADDR_W 10
// One weight per word
`define STILE_WBUF_DATA_W 16

// Activation buffer, 128 entries of one activation each
`define STILE_ACT_DATA_W 8
`define STILE_ACT_ADDR_W 7
// Write side addresses pairs, low bit comes from the phase
`define STILE_ACT_ADDRH_W 6

// Partial sum as wide as the accumulator
`define STILE_PSUM_W 48

`endif

/* logic/stile_top.sv */
// Compute tile top level: weight buffer, activation buffer and MAC pipeline
`timescale 1ns/1ps
`default_nettype none

`include "stile_macros.svh"

module stile_top #(
  parameter bit tile_odd = 1'b0 // Set for odd-indexed tiles in the array
) (
  input  wire logic                          clk_h,
  input  wire logic                          rst_n,
  input  wire stile_buf_pkg::wbuf_wr_t       wbuf_wr,      // Weight load
  input  wire logic [`STILE_WBUF_ADDR_W-1:0] wbuf_rd_addr,
  input  wire stile_buf_pkg::actbuf_wr_t     actbuf_wr,    // Held for a slow beat
  input  wire stile_buf_pkg::actbuf_rd_t     actbuf_rd,    // Held for a slow beat
  input  wire stile_mac_pkg::psum_src_e      psum_src,
  input  wire stile_mac_pkg::psum_t          psum_in,
  input  wire stile_mac_pkg::psum_t          psum_casin,   // From neighbour tile
  output wire stile_mac_pkg::psum_t          psum_out      // Also feeds next tile
);

  import stile_mac_pkg::*;

  weight_t weight; // Registered weight, two cycles after address
  act_t    act;    // Combinational activation

  weight_buf weight_buf_inst (
    .clk_h   (clk_h),
    .rst_n   (rst_n),
    .wr      (wbuf_wr),
    .rd_addr (wbuf_rd_addr),
    .weight  (weight)
  );

  act_buf act_buf_inst (
    .clk_h (clk_h),
    .rst_n (rst_n),
    .wr    (actbuf_wr),
    .rd    (actbuf_rd),
    .act   (act)
  );

  // Skew lives inside the MAC so both operands move together
  mac_unit #(
    .tile_odd (tile_odd)
  ) mac_unit_inst (
    .clk_h      (clk_h),
    .rst_n      (rst_n),
    .weight     (weight),
    .act        (act),
    .psum_src   (psum_src),
    .psum_in    (psum_in),
    .psum_casin (psum_casin),
    .psum_out   (psum_out)
  );

endmodule

`default_nettype wire

/* logic/weight_buf.sv */
// Weight RAM with a write port and a two-stage registered read
`timescale 1ns/1ps
`default_nettype none

`include "stile_macros.svh"

module weight_buf (
  input  wire logic                          clk_h,
  input  wire logic                          rst_n,
  input  wire stile_buf_pkg::wbuf_wr_t       wr,
  input  wire logic [`STILE_WBUF_ADDR_W-1:0] rd_addr,
  output stile_mac_pkg::weight_t             weight
);

  import stile_mac_pkg::*;

  localparam int WBUF_DEPTH = 1 << `STILE_WBUF_ADDR_W;

  weight_t mem [0:WBUF_DEPTH-1]; // Block RAM array, no init
  logic [`STILE_WBUF_ADDR_W-1:0] rd_addr_q; // Address register

  // Write port, one weight per cycle
  always_ff @(posedge clk_h) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Address register then output register
  // Weight is ready two edges after its address
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q <= '0;
      weight    <= '0;
    end else begin
      rd_addr_q <= rd_addr;
      weight    <= mem[rd_addr_q]; // Output register stage
    end
  end

endmodule

`default_nettype wire

/* sim/stile_tb_checks.svh */
// Typed compare tasks and failure reporting for the tile testbench
`ifndef STILE_TB_CHECKS_SVH
`define STILE_TB_CHECKS_SVH

int checks_done = 0; // Compares that actually ran

// Report the failure and stop the run
task automatic stop_on_failure();
  $display("Checks failed");
  $fatal(1, "Stopping at the first mismatch");
endtask

// Full partial sum against the model
task automatic check_psum(input string name, input psum_t got, input psum_t exp);
  checks_done++;
  if (got !== exp) begin
    $display("CHECK FAILED at %0d ns: %s got %h expected %h",
             $time, name, got, exp);
    stop_on_failure();
  end
endtask

// Weight seen through a product with activation 1 and no psum
task automatic check_weight_word(input string name, input weight_t got,
                                 input weight_t exp);
  checks_done++;
  if (got !== exp) begin
    $display("CHECK FAILED at %0d ns: %s got %h expected %h",
             $time, name, got, exp);
    stop_on_failure();
  end
endtask

`endif

/* sim/stile_tb.sv */
// Tile testbench: clock, reset, seeded random stimulus, watchdog and reference model
`timescale 1ns/1ps
`default_nettype none

`include "stile_macros.svh"

module stile_tb;
  import stile_buf_pkg::*;
  import stile_mac_pkg::*;

  localparam int S = 1;           // Odd tile, one skew cycle
  localparam int SEG_PRE = 1024;  // Preload of both memories
  localparam int SEG_WRD = SEG_PRE + 200; // Weight write and read
  localparam int SEG_ACT = SEG_WRD + 200; // Activation pairs
  localparam int SEG_LOC = SEG_ACT + 200; // Stream, local psum
  localparam int SEG_CAS = SEG_LOC + 200; // Stream, cascade psum
  localparam int N       = SEG_CAS + 200; // Stream, mixed source

  logic clk_h, rst_n;
  wbuf_wr_t wbuf_wr;
  logic [`STILE_WBUF_ADDR_W-1:0] wbuf_rd_addr;
  actbuf_wr_t actbuf_wr;
  actbuf_rd_t actbuf_rd;
  psum_src_e psum_src;
  psum_t psum_in, psum_casin, psum_out;

  integer seed = 63;
  weight_t wmem [0:1023];   // Model weight RAM
  act_t    amem [0:127];    // Model activation RAM
  logic    mphase;          // Model phase
  weight_t hist_w [0:N+1];  // Weight at the MAC input per edge
  act_t    hist_a [0:N+1];
  psum_src_e hist_src [0:N+1];
  psum_t   hist_pin [0:N+1];
  logic [`STILE_WBUF_ADDR_W-1:0] hist_raddr [0:N+1];
  logic [`STILE_ACT_ADDRH_W-1:0] last_addrh;

  `include "stile_tb_checks.svh"

  stile_top #(.tile_odd(1'b1)) stile_top_inst (
    .clk_h, .rst_n, .wbuf_wr, .wbuf_rd_addr, .actbuf_wr, .actbuf_rd,
    .psum_src, .psum_in, .psum_casin, .psum_out
  );

  initial begin
    clk_h = 1'b0;
    forever #20 clk_h = ~clk_h;
  end

  // Watchdog sized from the cycle count
  initial begin
    #((N + 50) * 40);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  function automatic psum_t rand48();
    return psum_t'({$random(seed), $random(seed)}); // Truncated to 48 bits
  endfunction

  // Inputs sampled at edge k
  task automatic drive_inputs(input int k);
    if (k < SEG_PRE) begin
      wbuf_wr = '{en: 1'b1, addr: k[9:0], data: weight_t'($random(seed))};
      actbuf_wr.en = (k < 128);
      actbuf_wr.addrh = k[6:1];
      if (k < 2) actbuf_wr.data.word = 16'h0101; // Activation 1 at entries 0 and 1
      else if (!k[0]) actbuf_wr.data.word = 16'($random(seed));
      wbuf_rd_addr = '0;
      actbuf_rd = '0;
    end else if (k < SEG_WRD) begin
      wbuf_wr = '{en: 1'($random(seed)), addr: 10'($random(seed)),
                  data: weight_t'($random(seed))};
      wbuf_rd_addr = 10'($random(seed));
      actbuf_wr.en = 1'b0;
      actbuf_rd = '0;
    end else if (k < SEG_ACT) begin
      wbuf_wr.en = 1'b0;
      wbuf_rd_addr = 10'($random(seed));
      if (!k[0]) begin // New slow beat
        actbuf_rd.addr = {last_addrh, 1'b0};
        actbuf_rd.increment = $random(seed) & 1 ? 7'd1 : 7'($random(seed));
        last_addrh = 6'(1 + ($unsigned($random(seed)) % 63));
        actbuf_wr.en = 1'b1;
        actbuf_wr.addrh = last_addrh;
        actbuf_wr.data.half.lo = act_t'($random(seed));
        actbuf_wr.data.half.hi = act_t'($random(seed));
      end
    end else begin
      wbuf_wr = '{en: 1'($random(seed)), addr: 10'($random(seed)),
                  data: weight_t'($random(seed))};
      wbuf_rd_addr = 10'($random(seed));
      if (!k[0]) begin
        actbuf_wr.en = 1'($random(seed));
        actbuf_wr.addrh = 6'(1 + ($unsigned($random(seed)) % 63));
        actbuf_wr.data.word = 16'($random(seed));
        actbuf_rd = actbuf_rd_t'(14'($random(seed)));
      end
      psum_in = rand48();
      psum_casin = rand48();
      if (k < SEG_LOC) psum_src = src_local;
      else if (k < SEG_CAS) psum_src = src_cascade;
      else psum_src = psum_src_e'(1'($random(seed)));
    end
  endtask

  // Advance the model by the edge k and check psum_out after it
  task automatic model_and_check(input int k);
    logic [6:0] ra;
    int idx;
    psum_t exp;
    psum_src_e src;
    ra = mphase ? actbuf_rd.addr + actbuf_rd.increment : actbuf_rd.addr;
    hist_a[k] = amem[ra];       // Read sees memory before this edge's write
    hist_src[k] = psum_src;
    hist_pin[k] = psum_in;
    hist_raddr[k] = wbuf_rd_addr;
    hist_w[k+1] = wmem[k >= 1 ? hist_raddr[k-1] : '0]; // Two-cycle weight read
    if (wbuf_wr.en) wmem[wbuf_wr.addr] = wbuf_wr.data;
    if (actbuf_wr.en)
      amem[{actbuf_wr.addrh, mphase}] = mphase ? actbuf_wr.data.half.hi
                                               : actbuf_wr.data.half.lo;
    mphase = ~mphase;
    idx = k - 2 - S; // Operands that reach psum_out at this edge
    src = idx >= 0 ? hist_src[idx] : src_local;
    exp = idx >= 0 ? psum_t'(hist_w[idx]) * psum_t'(hist_a[idx]) : '0;
    if (src == src_cascade) exp = exp + psum_casin; // Unregistered cascade
    else exp = exp + (k >= 1 ? hist_pin[k-1] : '0);
    if (!$isunknown(exp)) begin
      if (k >= SEG_PRE + 6 && k < SEG_WRD) begin
        check_weight_word("weight", weight_t'(psum_out), hist_w[idx]);
      end
      check_psum("psum_out", psum_out, exp);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    wbuf_wr = '0;
    wbuf_rd_addr = '0;
    actbuf_wr = '0;
    actbuf_rd = '0;
    psum_src = src_local;
    psum_in = '0;
    psum_casin = '0;
    last_addrh = 6'd1;
    mphase = 1'b0;
    hist_w[0] = '0; // Output register cleared in reset
    repeat (3) @(posedge clk_h);
    #2 rst_n = 1'b1;
    check_psum("psum_out", psum_out, '0); // Pipeline cleared in reset
    for (int k = 0; k < N; k++) begin
      drive_inputs(k);
      @(posedge clk_h);
      #1 model_and_check(k);
      #1;
    end
    if (checks_done < N - SEG_PRE) begin
      $display("Too few compares ran, the model stayed unknown");
      $display("Checks failed");
      $fatal(1, "Coverage of compares too low");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
